// File: apb_readback.sv
module apb_readback #(
    parameter int NUM_ARCH_REGS = retire_pkg::DEF_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = retire_pkg::DEF_NUM_PHYS_REGS
) (
    input  logic                                             clk,
    input  logic                                             rst,

    // APB3 slave
    input  logic                                             psel,
    input  logic                                             penable,
    input  logic                                             pwrite,
    input  logic [7:0]                                       paddr,
    input  logic [31:0]                                      pwdata, // Read-only bus, data dropped
    output logic [31:0]                                      prdata,
    output logic                                             pready,
    output logic                                             pslverr,

    // Sources of read data
    output logic [$clog2(NUM_ARCH_REGS)-1:0]                 map_rd_arch,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0]                 map_rd_phys,
    input  logic [$clog2(NUM_PHYS_REGS-NUM_ARCH_REGS+1)-1:0] free_count,
    input  logic [31:0]                                      retired_count
);

    import retire_pkg::*;

    localparam int AW = $clog2(NUM_ARCH_REGS);

    apb_state_e  state;
    logic        access;
    logic [31:0] rd_value;
    logic        rd_err;

    assign access      = psel && penable;
    assign map_rd_arch = paddr[AW-1:0];

    // Address decode
    always_comb begin
        rd_value = '0;
        rd_err   = 1'b0;
        if (pwrite) begin
            rd_err = 1'b1;
        end else if (int'(paddr) < NUM_ARCH_REGS) begin
            rd_value = 32'(map_rd_phys);
        end else if (int'(paddr) == ADDR_FREE_COUNT) begin
            rd_value = 32'(free_count);
        end else if (int'(paddr) == ADDR_RETIRED_COUNT) begin
            rd_value = retired_count;
        end else begin
            rd_err = 1'b1; // Unmapped
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= apb_idle;
            pready  <= 1'b0;
            pslverr <= 1'b0;
        end else begin
            case (state)
                apb_idle: begin
                    if (access) begin // First access cycle is the wait state
                        state   <= apb_wait;
                        pready  <= 1'b1;
                        pslverr <= rd_err;
                    end
                end
                apb_wait: begin
                    state   <= apb_idle;
                    pready  <= 1'b0;
                    pslverr <= 1'b0;
                end
                default: state <= apb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == apb_idle && access) begin
            prdata <= rd_value;
        end
    end

endmodule

// File: free_list.sv
module free_list #(
    parameter int NUM_ARCH_REGS = retire_pkg::DEF_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = retire_pkg::DEF_NUM_PHYS_REGS
) (
    input  logic                                             clk,
    input  logic                                             rst,

    // Pop side, dispatch handshake
    input  logic                                             alloc,
    output logic                                             free_empty,
    output logic [$clog2(NUM_PHYS_REGS)-1:0]                 head_phys,

    // Push side, displaced mappings
    input  logic                                             release_valid,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0]                 release_phys,

    output logic [$clog2(NUM_PHYS_REGS-NUM_ARCH_REGS+1)-1:0] free_count
);

    localparam int NUM_FREE = NUM_PHYS_REGS - NUM_ARCH_REGS;
    localparam int PW       = $clog2(NUM_PHYS_REGS);
    localparam int IW       = $clog2(NUM_FREE);
    localparam int FW       = $clog2(NUM_FREE + 1);

    logic [PW-1:0] free_mem [NUM_FREE];
    logic [IW-1:0] rd_ptr;
    logic [IW-1:0] wr_ptr;
    logic [FW-1:0] count;

    function automatic logic [IW-1:0] next_idx(input logic [IW-1:0] idx);
        next_idx = (idx == IW'(NUM_FREE - 1)) ? '0 : idx + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            // Starts full with every non-architectural register
            for (int i = 0; i < NUM_FREE; i++) begin
                free_mem[i] <= PW'(NUM_ARCH_REGS + i);
            end
            rd_ptr <= '0;
            wr_ptr <= '0; // Wrapped, list is full
            count  <= FW'(NUM_FREE);
        end else begin
            if (alloc) begin
                rd_ptr <= next_idx(rd_ptr);
            end

            // Cannot overflow, free plus in-flight is constant
            if (release_valid) begin
                free_mem[wr_ptr] <= release_phys;
                wr_ptr           <= next_idx(wr_ptr);
            end

            case ({alloc, release_valid})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign free_empty = (count == '0);
    assign head_phys  = free_mem[rd_ptr]; // Next register handed out
    assign free_count = count;

endmodule

// File: retire.f
retire_pkg.sv
rob_queue.sv
rrat.sv
free_list.sv
apb_readback.sv
retire_top.sv
retire_assert.sv
retire_tb.sv

// File: retire_assert.sv
module retire_checker #(
    parameter int NUM_ARCH_REGS = retire_pkg::DEF_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = retire_pkg::DEF_NUM_PHYS_REGS
) (
    input logic                                             clk,
    input logic                                             rst,
    input logic                                             dispatch_valid,
    input logic                                             dispatch_ready,
    input logic [$clog2(NUM_PHYS_REGS)-1:0]                 dispatch_phys,
    input logic                                             commit_valid,
    input logic [$clog2(NUM_PHYS_REGS)-1:0]                 commit_phys,
    input logic                                             release_valid,
    input logic [$clog2(NUM_PHYS_REGS-NUM_ARCH_REGS+1)-1:0] free_count,
    input logic [31:0]                                      retired_count,
    input logic                                             psel,
    input logic                                             penable,
    input logic                                             pwrite,
    input logic [7:0]                                       paddr,
    input logic                                             pready,
    input logic                                             pslverr
);

    import retire_pkg::*;

    localparam int NUM_FREE = NUM_PHYS_REGS - NUM_ARCH_REGS;

    int                       fail_count = 0;
    logic [NUM_PHYS_REGS-1:0] in_flight; // Registers held by queued entries
    logic                     accept;
    logic                     bad_access;

    assign accept     = dispatch_valid && dispatch_ready; // Handshake seen at the port
    assign bad_access = pwrite || (int'(paddr) >= NUM_ARCH_REGS
        && int'(paddr) != ADDR_FREE_COUNT && int'(paddr) != ADDR_RETIRED_COUNT);

    always_ff @(posedge clk) begin
        if (rst) begin
            in_flight <= '0;
        end else begin
            if (commit_valid) in_flight[commit_phys] <= 1'b0; // Entry left the queue
            if (accept) in_flight[dispatch_phys] <= 1'b1;
        end
    end

    a_dispatch: assert property (@(posedge clk) disable iff (rst)
        accept |-> !in_flight[dispatch_phys])
        else begin
            $error("Dispatch handed out a register already queued");
            fail_count++;
        end

    a_free_bound: assert property (@(posedge clk) disable iff (rst)
        int'(free_count) <= NUM_FREE)
        else begin
            $error("Free count above the number of spare registers");
            fail_count++;
        end

    // Pop and push in one cycle cancel out
    a_free_step: assert property (@(posedge clk) disable iff (rst)
        !rst |=> int'(free_count) == int'($past(free_count))
            + int'($past(release_valid && !accept)) - int'($past(accept && !release_valid)))
        else begin
            $error("Free count moved by the wrong amount");
            fail_count++;
        end

    // Each release follows the commit that bumped the counter
    a_retired_step: assert property (@(posedge clk) disable iff (rst)
        !rst |=> $past(retired_count) - $past(retired_count, 2) == 32'(release_valid))
        else begin
            $error("Retired count does not match the release pulses");
            fail_count++;
        end

    a_one_wait: assert property (@(posedge clk) disable iff (rst)
        (psel && !penable) |=> !pready ##1 pready)
        else begin
            $error("APB access did not take exactly one wait state");
            fail_count++;
        end

    a_slverr: assert property (@(posedge clk) disable iff (rst)
        (psel && penable && pready) |-> pslverr == bad_access)
        else begin
            $error("APB error response does not match the access");
            fail_count++;
        end

endmodule

bind retire_top retire_checker #(
    .NUM_ARCH_REGS (NUM_ARCH_REGS),
    .NUM_PHYS_REGS (NUM_PHYS_REGS)
) u_checker (.*);

// File: retire_pkg.sv
package retire_pkg;

    // Default core sizes, overridden only through retire_top
    localparam int DEF_NUM_ARCH_REGS = 16;
    localparam int DEF_NUM_PHYS_REGS = 32;
    localparam int DEF_ROB_DEPTH     = 8;

    // Reorder queue entry life cycle
    typedef enum logic [1:0] {
        entry_free = 2'd0, // Slot empty
        entry_busy = 2'd1, // Dispatched, waiting for completion
        entry_done = 2'd2  // Completed, waiting to commit
    } entry_state_e;

    // APB slave, one wait state per access
    typedef enum logic {
        apb_idle = 1'b0,
        apb_wait = 1'b1
    } apb_state_e;

    // APB read map
    // Addresses below NUM_ARCH_REGS return the committed mapping of that register
    localparam int ADDR_FREE_COUNT    = 32;
    localparam int ADDR_RETIRED_COUNT = 33;

endpackage

// File: retire_tb.sv
module retire_tb;

    import retire_pkg::*;

    localparam int AW         = $clog2(DEF_NUM_ARCH_REGS);
    localparam int PW         = $clog2(DEF_NUM_PHYS_REGS);
    localparam int TW         = $clog2(DEF_ROB_DEPTH);
    localparam int NUM_FREE   = DEF_NUM_PHYS_REGS - DEF_NUM_ARCH_REGS;
    localparam int NUM_BURSTS = 6;
    localparam int BURST_LEN  = 40;
    localparam int NUM_OPS    = NUM_BURSTS * BURST_LEN + 80; // Traffic cycles plus bus reads

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    logic          dispatch_valid = 1'b0;
    logic [AW-1:0] dispatch_arch = '0;
    logic          dispatch_ready;
    logic [PW-1:0] dispatch_phys;
    logic [TW-1:0] dispatch_tag;
    logic          complete_valid = 1'b0;
    logic [TW-1:0] complete_tag = '0;
    logic          psel = 1'b0;
    logic          penable = 1'b0;
    logic          pwrite = 1'b0;
    logic [7:0]    paddr = '0;
    logic [31:0]   pwdata = '0;
    logic [31:0]   prdata;
    logic          pready;
    logic          pslverr;

    int            errors = 0;
    int            cyc = 0;          // Edges since reset release
    int            n_disp = 0;
    int            commit_ptr = 0;
    int            release_ptr = 0;
    logic [31:0]   seed = 32'h615;
    logic [PW-1:0] last_phys [DEF_NUM_ARCH_REGS];
    logic [PW-1:0] phys_of [512];
    int            done_at [512];    // 0 while busy
    int            commit_at [512];

    retire_top u_retire_top (.*);

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // Advance one edge, replay commits and releases, then check ready
    task automatic tick();
        int   free_regs;
        logic exp_ready;
        @(posedge clk);
        #2;
        cyc++;
        dispatch_valid = 1'b0;
        complete_valid = 1'b0;
        if (commit_ptr < n_disp && done_at[commit_ptr] != 0 && done_at[commit_ptr] < cyc) begin
            commit_at[commit_ptr] = cyc;
            commit_ptr++;
        end
        while (release_ptr < commit_ptr && commit_at[release_ptr] + 2 <= cyc) release_ptr++;
        free_regs = NUM_FREE - (n_disp - release_ptr);
        exp_ready = (n_disp - commit_ptr < DEF_ROB_DEPTH) && (free_regs > 0);
        if (dispatch_ready !== exp_ready) begin
            errors++;
            $display("Fail %0t: dispatch_ready %b with %0d queued and %0d free", $time,
                     dispatch_ready, n_disp - commit_ptr, free_regs);
        end
    endtask

    task automatic apb_access(input logic wr, input logic [7:0] addr,
                              output logic [31:0] rdata, output logic err);
        int waits;
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = lcg_next(); // Ignored by the slave
        tick();
        penable = 1'b1;
        waits   = 0;
        do begin
            tick();
            waits++;
        end while (!pready && waits < 8);
        if (!pready) begin
            errors++;
            $display("APB slave never answered the access to address %0d", addr);
        end
        rdata = prdata;
        err   = pslverr;
        tick();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] addr, input logic [31:0] expected);
        logic [31:0] rdata;
        logic        err;
        apb_access(1'b0, addr, rdata, err);
        if (err || rdata !== expected) begin
            errors++;
            $display("Fail %0t: address %0d read %0d err %b, expected %0d", $time,
                     addr, rdata, err, expected);
        end
    endtask

    task automatic error_check(input logic wr, input logic [7:0] addr);
        logic [31:0] rdata;
        logic        err;
        apb_access(wr, addr, rdata, err);
        if (err !== 1'b1) begin
            errors++;
            $display("Fail %0t: access to address %0d gave pslverr %b", $time, addr, err);
        end
    endtask

    // One cycle of random dispatch and out-of-order completion
    task automatic traffic_step(input bit do_dispatch, input bit do_complete);
        int          busy [$];
        int          pick;
        logic [31:0] r;
        r = lcg_next();
        for (int s = commit_ptr; s < n_disp; s++) begin
            if (done_at[s] == 0) busy.push_back(s);
        end
        if (do_complete && busy.size() > 0 && r[20]) begin
            pick           = busy[r[31:24] % busy.size()];
            complete_valid = 1'b1;
            complete_tag   = TW'(pick % DEF_ROB_DEPTH);
            done_at[pick]  = cyc + 1;
        end
        if (do_dispatch && r[3:0] < 4'd11) begin
            dispatch_valid = 1'b1; // Also driven while not ready
            dispatch_arch  = r[11:8];
            if (dispatch_ready) begin
                for (int s = commit_ptr; s < n_disp; s++) begin
                    if (phys_of[s] == dispatch_phys) begin
                        errors++;
                        $display("Fail %0t: register %0d handed out twice", $time, dispatch_phys);
                    end
                end
                if (dispatch_tag !== TW'(n_disp % DEF_ROB_DEPTH)) begin
                    errors++;
                    $display("Fail %0t: dispatch_tag %0d is not the tail", $time, dispatch_tag);
                end
                phys_of[n_disp]     = dispatch_phys;
                last_phys[r[11:8]] = dispatch_phys;
                n_disp++;
            end
        end
        tick();
    endtask

    initial begin
        int prefix;
        for (int r = 0; r < DEF_NUM_ARCH_REGS; r++) last_phys[r] = PW'(r);
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int r = 0; r < DEF_NUM_ARCH_REGS; r++) read_check(r, r);
        read_check(ADDR_FREE_COUNT, NUM_FREE);
        read_check(ADDR_RETIRED_COUNT, 0);
        error_check(1'b1, 8'd3);
        error_check(1'b0, 8'd40);
        read_check(8'd3, 32'd3);

        for (int b = 0; b < NUM_BURSTS; b++) begin
            repeat (BURST_LEN) traffic_step(1'b1, b % 3 != 1); // Some bursts fill the queue
            repeat (12) tick();
            prefix = 0;
            while (prefix < n_disp && done_at[prefix] != 0) prefix++;
            read_check(ADDR_RETIRED_COUNT, prefix);
        end

        while (commit_ptr < n_disp) traffic_step(1'b0, 1'b1);
        repeat (6) tick();
        for (int r = 0; r < DEF_NUM_ARCH_REGS; r++) read_check(r, last_phys[r]);
        read_check(ADDR_FREE_COUNT, NUM_FREE);
        read_check(ADDR_RETIRED_COUNT, n_disp);

        $display("Model errors %0d, assertion errors %0d", errors,
                 u_retire_top.u_checker.fail_count);
        if (errors == 0 && u_retire_top.u_checker.fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(NUM_OPS * 40 * 20 + 5000);
        $display("Run timed out before all tests finished");
        $display("sim failed");
        $finish;
    end

endmodule

// File: retire_top.sv
module retire_top #(
    parameter int NUM_ARCH_REGS = retire_pkg::DEF_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = retire_pkg::DEF_NUM_PHYS_REGS,
    parameter int ROB_DEPTH     = retire_pkg::DEF_ROB_DEPTH
) (
    input  logic                             clk,
    input  logic                             rst,

    input  logic                             dispatch_valid,
    input  logic [$clog2(NUM_ARCH_REGS)-1:0] dispatch_arch,
    output logic                             dispatch_ready,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] dispatch_phys,
    output logic [$clog2(ROB_DEPTH)-1:0]     dispatch_tag,

    input  logic                             complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0]     complete_tag,

    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [7:0]                       paddr,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr
);

    localparam int AW = $clog2(NUM_ARCH_REGS);
    localparam int PW = $clog2(NUM_PHYS_REGS);
    localparam int FW = $clog2(NUM_PHYS_REGS - NUM_ARCH_REGS + 1);

    logic          free_empty;
    logic [PW-1:0] head_phys;
    logic          alloc;
    logic          commit_valid;
    logic [AW-1:0] commit_arch;
    logic [PW-1:0] commit_phys;
    logic          release_valid;
    logic [PW-1:0] release_phys;
    logic [AW-1:0] map_rd_arch;
    logic [PW-1:0] map_rd_phys;
    logic [FW-1:0] free_count;
    logic [31:0]   retired_count;

    assign dispatch_phys = head_phys; // Free list head goes out with the handshake

    rob_queue #(
        .NUM_ARCH_REGS (NUM_ARCH_REGS),
        .NUM_PHYS_REGS (NUM_PHYS_REGS),
        .ROB_DEPTH     (ROB_DEPTH)
    ) u_rob (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_arch  (dispatch_arch),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .free_empty     (free_empty),
        .head_phys      (head_phys),
        .alloc          (alloc),
        .commit_valid   (commit_valid),
        .commit_arch    (commit_arch),
        .commit_phys    (commit_phys),
        .retired_count  (retired_count)
    );

    rrat #(
        .NUM_ARCH_REGS (NUM_ARCH_REGS),
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_rrat (
        .clk           (clk),
        .rst           (rst),
        .commit_valid  (commit_valid),
        .commit_arch   (commit_arch),
        .commit_phys   (commit_phys),
        .release_valid (release_valid),
        .release_phys  (release_phys),
        .map_rd_arch   (map_rd_arch),
        .map_rd_phys   (map_rd_phys)
    );

    free_list #(
        .NUM_ARCH_REGS (NUM_ARCH_REGS),
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_free (
        .clk           (clk),
        .rst           (rst),
        .alloc         (alloc),
        .free_empty    (free_empty),
        .head_phys     (head_phys),
        .release_valid (release_valid),
        .release_phys  (release_phys),
        .free_count    (free_count)
    );

    apb_readback #(
        .NUM_ARCH_REGS (NUM_ARCH_REGS),
        .NUM_PHYS_REGS (NUM_PHYS_REGS)
    ) u_apb (
        .clk           (clk),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .map_rd_arch   (map_rd_arch),
        .map_rd_phys   (map_rd_phys),
        .free_count    (free_count),
        .retired_count (retired_count)
    );

endmodule

// File: rob_queue.sv
module rob_queue #(
    parameter int NUM_ARCH_REGS = retire_pkg::DEF_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = retire_pkg::DEF_NUM_PHYS_REGS,
    parameter int ROB_DEPTH     = retire_pkg::DEF_ROB_DEPTH
) (
    input  logic                             clk,
    input  logic                             rst,

    // Dispatch port
    input  logic                             dispatch_valid,
    input  logic [$clog2(NUM_ARCH_REGS)-1:0] dispatch_arch,
    output logic                             dispatch_ready,
    output logic [$clog2(ROB_DEPTH)-1:0]     dispatch_tag,

    // Completion port
    input  logic                             complete_valid,
    input  logic [$clog2(ROB_DEPTH)-1:0]     complete_tag,

    // Free list side
    input  logic                             free_empty,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0] head_phys,
    output logic                             alloc,

    // Commit pulse towards the alias table
    output logic                             commit_valid,
    output logic [$clog2(NUM_ARCH_REGS)-1:0] commit_arch,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] commit_phys,

    output logic [31:0]                      retired_count
);

    import retire_pkg::*;

    localparam int AW = $clog2(NUM_ARCH_REGS);
    localparam int PW = $clog2(NUM_PHYS_REGS);
    localparam int TW = $clog2(ROB_DEPTH);
    localparam int CW = $clog2(ROB_DEPTH + 1);

    entry_state_e    entry_state [ROB_DEPTH];
    logic [AW-1:0]   entry_arch  [ROB_DEPTH];
    logic [PW-1:0]   entry_phys  [ROB_DEPTH];

    logic [TW-1:0]   head;
    logic [TW-1:0]   tail;
    logic [CW-1:0]   count;
    logic            full;
    logic            do_commit;

    // Circular pointer advance, depth need not be a power of two
    function automatic logic [TW-1:0] next_ptr(input logic [TW-1:0] ptr);
        next_ptr = (ptr == TW'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full           = (count == CW'(ROB_DEPTH));
    assign dispatch_ready = !full && !free_empty;
    assign alloc          = dispatch_valid && dispatch_ready; // Pops the free list
    assign dispatch_tag   = tail;

    // Head slot reads free when the queue is empty
    assign do_commit = (entry_state[head] == entry_done);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ROB_DEPTH; i++) begin
                entry_state[i] <= entry_free;
            end
            head          <= '0;
            tail          <= '0;
            count         <= '0;
            commit_valid  <= 1'b0;
            retired_count <= '0;
        end else begin
            // Late or duplicate completions leave the entry alone
            if (complete_valid && entry_state[complete_tag] == entry_busy) begin
                entry_state[complete_tag] <= entry_done;
            end

            if (alloc) begin
                entry_state[tail] <= entry_busy;
                tail              <= next_ptr(tail);
            end

            if (do_commit) begin
                entry_state[head] <= entry_free;
                head              <= next_ptr(head);
                retired_count     <= retired_count + 32'd1;
            end

            commit_valid <= do_commit; // One cycle pulse

            case ({alloc, do_commit})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;      // Both or neither
            endcase
        end
    end

    // Entry payload and commit data
    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_arch[tail] <= dispatch_arch;
            entry_phys[tail] <= head_phys;
        end
        if (do_commit) begin
            commit_arch <= entry_arch[head];
            commit_phys <= entry_phys[head];
        end
    end

endmodule

// File: rrat.sv
module rrat #(
    parameter int NUM_ARCH_REGS = retire_pkg::DEF_NUM_ARCH_REGS,
    parameter int NUM_PHYS_REGS = retire_pkg::DEF_NUM_PHYS_REGS
) (
    input  logic                             clk,
    input  logic                             rst,

    // Commit pulse from the reorder queue
    input  logic                             commit_valid,
    input  logic [$clog2(NUM_ARCH_REGS)-1:0] commit_arch,
    input  logic [$clog2(NUM_PHYS_REGS)-1:0] commit_phys,

    // Displaced mapping back to the free list
    output logic                             release_valid,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] release_phys,

    // Bus read port
    input  logic [$clog2(NUM_ARCH_REGS)-1:0] map_rd_arch,
    output logic [$clog2(NUM_PHYS_REGS)-1:0] map_rd_phys
);

    localparam int PW = $clog2(NUM_PHYS_REGS);

    // Committed architectural to physical mapping
    logic [PW-1:0] rrat_table [NUM_ARCH_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                rrat_table[i] <= PW'(i); // Identity mapping
            end
            release_valid <= 1'b0;
        end else begin
            if (commit_valid) begin
                rrat_table[commit_arch] <= commit_phys;
            end
            release_valid <= commit_valid;
        end
    end

    // Old mapping is read before the table write lands
    always_ff @(posedge clk) begin
        if (commit_valid) begin
            release_phys <= rrat_table[commit_arch];
        end
    end

    assign map_rd_phys = rrat_table[map_rd_arch];

endmodule
